// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := soc_periph_tb
FILELIST := all.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+hdl
hdl/soc_periph_pkg.sv
hdl/periph_bus_decoder.sv
hdl/gpio_unit.sv
hdl/ref_timer_unit.sv
hdl/soc_event_gen.sv
hdl/soc_periph_top.sv
sim/tb_clock_gen.sv
sim/soc_periph_tb.sv

// ==== hdl/gpio_unit.sv ====
//////////////////////////////////////////////////
// GPIO block with APB registers
// Direction, output and interrupt enable registers,
// two-flop input synchronizer, rising-edge interrupts
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module gpio_unit
    import soc_periph_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    // APB slave
    input  apb_req_t           apb_req_i,
    output periph_rsp_t        apb_rsp_o,
    // Pads
    input  logic [`GPIO_W-1:0] gpio_in_i,
    output logic [`GPIO_W-1:0] gpio_out_o,
    output logic [`GPIO_W-1:0] gpio_dir_o,
    // Interrupt towards the event generator
    output logic               gpio_irq_o
);

    gpio_reg_e          reg_sel;
    logic               wr_en;
    logic [`GPIO_W-1:0] wdata;
    logic [`GPIO_W-1:0] dir_q;
    logic [`GPIO_W-1:0] out_q;
    logic [`GPIO_W-1:0] int_en_q;
    logic [`GPIO_W-1:0] int_status_q;
    logic [`GPIO_W-1:0] sync1_q;
    logic [`GPIO_W-1:0] sync2_q;
    logic [`GPIO_W-1:0] prev_q;
    logic [`GPIO_W-1:0] rise_en;
    logic [`GPIO_W-1:0] status_clr;

    assign reg_sel = gpio_reg_e'(apb_req_i.paddr[`REG_MSB:`REG_LSB]);
    // Write lands at the end of the access cycle
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign wdata   = apb_req_i.pwdata[`GPIO_W-1:0];

    //////////////////////////////////////////////////
    // Input sync and edge detect
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            // Delayed copy for the edge compare
            prev_q  <= sync2_q;
        end
    end

    // Rising edges on enabled pads only
    assign rise_en    = sync2_q & ~prev_q & int_en_q;
    // Write-one-to-clear on the status register
    assign status_clr = (wr_en && reg_sel == GPIO_INT_STATUS) ? wdata : '0;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q        <= '0;
            out_q        <= '0;
            int_en_q     <= '0;
            int_status_q <= '0;
        end else begin
            // A new edge wins over a clear in the same cycle
            int_status_q <= (int_status_q & ~status_clr) | rise_en;
            if (wr_en) begin
                case (reg_sel)
                    GPIO_DIR:    dir_q    <= wdata;
                    GPIO_OUT:    out_q    <= wdata;
                    GPIO_INT_EN: int_en_q <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read mux and error flag
    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pslverr = 1'b0;
        case (reg_sel)
            GPIO_DIR:        apb_rsp_o.prdata = dir_q;
            GPIO_OUT:        apb_rsp_o.prdata = out_q;
            GPIO_INT_EN:     apb_rsp_o.prdata = int_en_q;
            GPIO_INT_STATUS: apb_rsp_o.prdata = int_status_q;
            GPIO_IN: begin
                apb_rsp_o.prdata  = sync2_q;
                // Read-only
                apb_rsp_o.pslverr = apb_req_i.psel & apb_req_i.pwrite;
            end
            default: apb_rsp_o.pslverr = apb_req_i.psel;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_irq_o = |int_status_q;

endmodule

// ==== hdl/periph_bus_decoder.sv ====
//////////////////////////////////////////////////
// APB slot decoder
// Forwards psel to one peripheral slot and muxes
// its response back, unmapped slots flag an error
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module periph_bus_decoder
    import soc_periph_pkg::*;
(
    // Master side
    input  apb_req_t    apb_req_i,
    output apb_rsp_t    apb_rsp_o,
    // Peripheral requests
    output apb_req_t    gpio_req_o,
    output apb_req_t    timer_req_o,
    output apb_req_t    event_req_o,
    // Peripheral responses
    input  periph_rsp_t gpio_rsp_i,
    input  periph_rsp_t timer_rsp_i,
    input  periph_rsp_t event_rsp_i
);

    periph_slot_e slot;

    // Slot field of the address
    assign slot = periph_slot_e'(apb_req_i.paddr[`SLOT_MSB:`SLOT_LSB]);

    //////////////////////////////////////////////////
    // Request fan-out
    //////////////////////////////////////////////////
    always_comb begin
        gpio_req_o  = apb_req_i;
        timer_req_o = apb_req_i;
        event_req_o = apb_req_i;
        // Only the addressed slot sees psel
        gpio_req_o.psel  = apb_req_i.psel & (slot == SLOT_GPIO);
        timer_req_o.psel = apb_req_i.psel & (slot == SLOT_TIMER);
        event_req_o.psel = apb_req_i.psel & (slot == SLOT_EVENT);
    end

    //////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////
    always_comb begin
        // Zero wait states, every access completes at once
        apb_rsp_o.pready = 1'b1;
        case (slot)
            SLOT_GPIO: begin
                apb_rsp_o.prdata  = gpio_rsp_i.prdata;
                apb_rsp_o.pslverr = gpio_rsp_i.pslverr;
            end
            SLOT_TIMER: begin
                apb_rsp_o.prdata  = timer_rsp_i.prdata;
                apb_rsp_o.pslverr = timer_rsp_i.pslverr;
            end
            SLOT_EVENT: begin
                apb_rsp_o.prdata  = event_rsp_i.prdata;
                apb_rsp_o.pslverr = event_rsp_i.pslverr;
            end
            default: begin
                // Nothing mapped here
                apb_rsp_o.prdata  = '0;
                apb_rsp_o.pslverr = apb_req_i.psel;
            end
        endcase
    end

endmodule

// ==== hdl/ref_timer_unit.sv ====
//////////////////////////////////////////////////
// Reference-clock timer
// Slow clock synchronizer and edge detector,
// compare counter with wrap, APB registers
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module ref_timer_unit
    import soc_periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    // APB slave
    input  apb_req_t    apb_req_i,
    output periph_rsp_t apb_rsp_o,
    // Slow reference clock sampled as data
    input  logic        slow_clk_i,
    // Freeze from the debug side
    input  logic        stoptimer_i,
    // Events
    output logic        timer_irq_o,
    output logic        ref_edge_o
);

    timer_reg_e             reg_sel;
    logic                   wr_en;
    logic                   slow_s1_q;
    logic                   slow_s2_q;
    logic                   slow_s3_q;
    logic                   ref_rise;
    logic                   ref_any;
    logic                   enable_q;
    logic [`APB_DATA_W-1:0] count_q;
    logic [`APB_DATA_W-1:0] cmp_q;
    logic [`APB_DATA_W-1:0] count_inc;
    logic                   count_step;
    logic                   count_match;
    logic                   irq_q;
    logic                   ref_edge_q;

    assign reg_sel = timer_reg_e'(apb_req_i.paddr[`REG_MSB:`REG_LSB]);
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    //////////////////////////////////////////////////
    // Slow clock sync and edges
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slow_s1_q <= 1'b0;
            slow_s2_q <= 1'b0;
            slow_s3_q <= 1'b0;
        end else begin
            slow_s1_q <= slow_clk_i;
            slow_s2_q <= slow_s1_q;
            slow_s3_q <= slow_s2_q;
        end
    end

    assign ref_rise = slow_s2_q & ~slow_s3_q;
    // Either edge
    assign ref_any  = slow_s2_q ^ slow_s3_q;

    // Counter step on enabled, unfrozen rising edges
    assign count_step  = ref_rise & enable_q & ~stoptimer_i;
    assign count_inc   = count_q + 1;
    // Hit when this edge brings the count to CMP
    assign count_match = (count_inc == cmp_q);

    //////////////////////////////////////////////////
    // Registers and counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q   <= 1'b0;
            cmp_q      <= '0;
            count_q    <= '0;
            irq_q      <= 1'b0;
            ref_edge_q <= 1'b0;
        end else begin
            irq_q      <= count_step & count_match;
            ref_edge_q <= ref_any;
            if (wr_en && reg_sel == TIMER_CTRL) begin
                enable_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && reg_sel == TIMER_CMP) begin
                cmp_q <= apb_req_i.pwdata;
            end
            // Software write has priority over counting
            if (wr_en && reg_sel == TIMER_COUNT) begin
                count_q <= apb_req_i.pwdata;
            end else if (count_step) begin
                count_q <= count_match ? '0 : count_inc;
            end
        end
    end

    // Read mux
    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pslverr = 1'b0;
        case (reg_sel)
            TIMER_CTRL:  apb_rsp_o.prdata[0] = enable_q;
            TIMER_COUNT: apb_rsp_o.prdata    = count_q;
            TIMER_CMP:   apb_rsp_o.prdata    = cmp_q;
            default:     apb_rsp_o.pslverr   = apb_req_i.psel;
        endcase
    end

    assign timer_irq_o = irq_q;
    assign ref_edge_o  = ref_edge_q;

endmodule

// ==== hdl/soc_event_gen.sv ====
//////////////////////////////////////////////////
// Fast-controller event generator
// Mask and software event registers, bit placement
// of peripheral events, registered event vector
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module soc_event_gen
    import soc_periph_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    // APB slave
    input  apb_req_t            apb_req_i,
    output periph_rsp_t         apb_rsp_o,
    // Peripheral events
    input  soc_events_t         events_i,
    // Event vector to the fast controller
    output logic [`FC_EV_W-1:0] fc_events_o
);

    event_reg_e          reg_sel;
    logic                wr_en;
    logic [`SW_EV_W-1:0] sw_ev;
    logic [`FC_EV_W-1:0] mask_q;
    logic [`FC_EV_W-1:0] ev_vec;
    logic [`FC_EV_W-1:0] fc_ev_q;

    assign reg_sel = event_reg_e'(apb_req_i.paddr[`REG_MSB:`REG_LSB]);
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    // Software events only live for the access cycle of the write
    assign sw_ev = (wr_en && reg_sel == EV_SW) ? apb_req_i.pwdata[`SW_EV_W-1:0] : '0;

    //////////////////////////////////////////////////
    // Event bit map
    //////////////////////////////////////////////////
    always_comb begin
        ev_vec                  = '0;
        ev_vec[`SW_EV_W-1:0]    = sw_ev;
        // Timer match drives both MTIME and timer lines
        ev_vec[`EV_MTIME_BIT]   = events_i.timer_irq;
        ev_vec[`EV_TIMER_BIT]   = events_i.timer_irq;
        ev_vec[`EV_GPIO_BIT]    = events_i.gpio_irq;
        ev_vec[`EV_REF_BIT]     = events_i.ref_edge;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q  <= `MASK_RST;
            fc_ev_q <= '0;
        end else begin
            // Masked and registered
            fc_ev_q <= ev_vec & mask_q;
            if (wr_en && reg_sel == EV_MASK) begin
                mask_q <= apb_req_i.pwdata[`FC_EV_W-1:0];
            end
        end
    end

    // Read mux, EV_SW reads back as zero
    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pslverr = 1'b0;
        case (reg_sel)
            EV_MASK: apb_rsp_o.prdata  = mask_q;
            EV_SW:   apb_rsp_o.prdata  = '0;
            default: apb_rsp_o.pslverr = apb_req_i.psel;
        endcase
    end

    assign fc_events_o = fc_ev_q;

endmodule

// ==== hdl/soc_periph_consts.svh ====
//////////////////////////////////////////////////
// Shared constants of the peripheral subsystem
// APB widths, slot and register address fields,
// pad count, event bit map and reset values
//////////////////////////////////////////////////

`ifndef SOC_PERIPH_CONSTS_SVH
`define SOC_PERIPH_CONSTS_SVH

// APB bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32

// Slot select and register select fields of paddr
`define SLOT_LSB 12
`define SLOT_MSB 15
`define REG_LSB 2
`define REG_MSB 4

// Pad count and fast-controller event vector width
`define GPIO_W 32
`define FC_EV_W 32

// Event vector layout
`define SW_EV_W 7
`define EV_MTIME_BIT 7
`define EV_TIMER_BIT 16
`define EV_GPIO_BIT 18
`define EV_REF_BIT 23

// All events enabled out of reset
`define MASK_RST 32'hffff_ffff

`endif

// ==== hdl/soc_periph_pkg.sv ====
//////////////////////////////////////////////////
// Types of the peripheral subsystem
// APB request and response structs, event struct,
// slot and register enums
//////////////////////////////////////////////////

`include "soc_periph_consts.svh"

package soc_periph_pkg;

    // APB request from the master
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic                   pwrite;
        logic [`APB_DATA_W-1:0] pwdata;
        logic                   psel;
        logic                   penable;
    } apb_req_t;

    // Response at the top-level port
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // Response of one peripheral without pready
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pslverr;
    } periph_rsp_t;

    // Peripheral slots selected by paddr[15:12]
    typedef enum logic [`SLOT_MSB-`SLOT_LSB:0] {
        SLOT_GPIO  = 4'd0,
        SLOT_TIMER = 4'd1,
        SLOT_EVENT = 4'd2
    } periph_slot_e;

    // GPIO register offsets (word index)
    typedef enum logic [`REG_MSB-`REG_LSB:0] {
        GPIO_DIR        = 3'd0,
        GPIO_OUT        = 3'd1,
        GPIO_IN         = 3'd2,
        GPIO_INT_EN     = 3'd3,
        GPIO_INT_STATUS = 3'd4
    } gpio_reg_e;

    // Timer register offsets
    typedef enum logic [`REG_MSB-`REG_LSB:0] {
        TIMER_CTRL  = 3'd0,
        TIMER_COUNT = 3'd1,
        TIMER_CMP   = 3'd2
    } timer_reg_e;

    // Event generator register offsets
    typedef enum logic [`REG_MSB-`REG_LSB:0] {
        EV_MASK = 3'd0,
        EV_SW   = 3'd1
    } event_reg_e;

    // Peripheral events into the event generator
    typedef struct packed {
        logic timer_irq;
        logic ref_edge;
        logic gpio_irq;
    } soc_events_t;

endpackage

// ==== hdl/soc_periph_top.sv ====
//////////////////////////////////////////////////
// Peripheral subsystem top level
// APB decoder, GPIO, reference timer and
// fast-controller event generator
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module soc_periph_top
    import soc_periph_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    // APB slave port
    input  apb_req_t            apb_req_i,
    output apb_rsp_t            apb_rsp_o,
    // Pads
    input  logic [`GPIO_W-1:0]  gpio_in_i,
    output logic [`GPIO_W-1:0]  gpio_out_o,
    output logic [`GPIO_W-1:0]  gpio_dir_o,
    // Timer inputs
    input  logic                slow_clk_i,
    input  logic                stoptimer_i,
    // Events
    output logic [`FC_EV_W-1:0] fc_events_o
);

    apb_req_t    gpio_req;
    apb_req_t    timer_req;
    apb_req_t    event_req;
    periph_rsp_t gpio_rsp;
    periph_rsp_t timer_rsp;
    periph_rsp_t event_rsp;
    soc_events_t periph_events;

    //////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////
    periph_bus_decoder i_periph_bus_decoder (
        .apb_req_i   ( apb_req_i ),
        .apb_rsp_o   ( apb_rsp_o ),
        .gpio_req_o  ( gpio_req  ),
        .timer_req_o ( timer_req ),
        .event_req_o ( event_req ),
        .gpio_rsp_i  ( gpio_rsp  ),
        .timer_rsp_i ( timer_rsp ),
        .event_rsp_i ( event_rsp )
    );

    //////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////
    gpio_unit i_gpio_unit (
        .clk_i      ( clk_i                  ),
        .arst_n_i   ( arst_n_i               ),
        .apb_req_i  ( gpio_req               ),
        .apb_rsp_o  ( gpio_rsp               ),
        .gpio_in_i  ( gpio_in_i              ),
        .gpio_out_o ( gpio_out_o             ),
        .gpio_dir_o ( gpio_dir_o             ),
        .gpio_irq_o ( periph_events.gpio_irq )
    );

    ref_timer_unit i_ref_timer_unit (
        .clk_i       ( clk_i                   ),
        .arst_n_i    ( arst_n_i                ),
        .apb_req_i   ( timer_req               ),
        .apb_rsp_o   ( timer_rsp               ),
        .slow_clk_i  ( slow_clk_i              ),
        .stoptimer_i ( stoptimer_i             ),
        .timer_irq_o ( periph_events.timer_irq ),
        .ref_edge_o  ( periph_events.ref_edge  )
    );

    // Event vector out
    soc_event_gen i_soc_event_gen (
        .clk_i       ( clk_i         ),
        .arst_n_i    ( arst_n_i      ),
        .apb_req_i   ( event_req     ),
        .apb_rsp_o   ( event_rsp     ),
        .events_i    ( periph_events ),
        .fc_events_o ( fc_events_o   )
    );

endmodule

// ==== sim/soc_periph_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the peripheral subsystem
// APB tasks, LFSR stimulus, checking assertions,
// event monitor, watchdog and summary
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_periph_consts.svh"

module soc_periph_tb
    import soc_periph_pkg::*;
();

    // Run length budget in clock cycles
    localparam int XFERS     = 48;
    localparam int TOGGLES   = 24;
    localparam int EDGE_HOLD = 8;
    localparam int LIMIT_CYC = 2 * (XFERS * 3 + TOGGLES * EDGE_HOLD + 80);

    // Event bits that the map can drive
    localparam logic [`FC_EV_W-1:0] EV_USED = ((32'h1 << `SW_EV_W) - 32'h1)
        | (32'h1 << `EV_MTIME_BIT) | (32'h1 << `EV_TIMER_BIT)
        | (32'h1 << `EV_GPIO_BIT) | (32'h1 << `EV_REF_BIT);

    logic                clk;
    logic                arst_n;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic [`GPIO_W-1:0]  gpio_in;
    logic [`GPIO_W-1:0]  gpio_out;
    logic [`GPIO_W-1:0]  gpio_dir;
    logic                slow_clk;
    logic                stoptimer;
    logic [`FC_EV_W-1:0] fc_events;

    // Expected bus and pad values
    logic                   rd_chk;
    logic [`APB_DATA_W-1:0] rd_exp;
    logic                   err_exp;
    logic [`GPIO_W-1:0]     dir_exp;
    logic [`GPIO_W-1:0]     out_exp;
    logic [31:0]            lfsr = 32'hddce_ece8;

    // Event pulse counters, written by the monitor only
    int                  mtime_cnt = 0;
    int                  timer_cnt = 0;
    int                  ref_cnt   = 0;
    int                  sw_cnt    = 0;
    logic [`SW_EV_W-1:0] sw_last   = '0;

    // Error counters, one per checker
    int rd_errs  = 0;
    int bus_errs = 0;
    int pad_errs = 0;
    int ev_errs  = 0;
    int val_errs = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    soc_periph_top i_soc_periph_top (
        .clk_i       ( clk       ),
        .arst_n_i    ( arst_n    ),
        .apb_req_i   ( apb_req   ),
        .apb_rsp_o   ( apb_rsp   ),
        .gpio_in_i   ( gpio_in   ),
        .gpio_out_o  ( gpio_out  ),
        .gpio_dir_o  ( gpio_dir  ),
        .slow_clk_i  ( slow_clk  ),
        .stoptimer_i ( stoptimer ),
        .fc_events_o ( fc_events )
    );

    //////////////////////////////////////////////////
    // Checking assertions
    //////////////////////////////////////////////////
    rd_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        rd_chk |-> (apb_rsp.prdata == rd_exp))
        else begin
            rd_errs++;
            $display("Fail prdata: got %h, expected %h", $sampled(apb_rsp.prdata), rd_exp);
        end

    // Every access cycle completes at once with the expected error flag
    bus_rsp_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.psel && apb_req.penable) |-> (apb_rsp.pready && apb_rsp.pslverr == err_exp))
        else begin
            bus_errs++;
            $display("Fail pslverr: got %h, expected %h, pready %h",
                $sampled(apb_rsp.pslverr), err_exp, $sampled(apb_rsp.pready));
        end

    pads_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (gpio_out == out_exp) && (gpio_dir == dir_exp))
        else begin
            pad_errs++;
            $display("Fail gpio_out_o/gpio_dir_o: got %h/%h, expected %h/%h",
                $sampled(gpio_out), $sampled(gpio_dir), out_exp, dir_exp);
        end

    // Timer match drives both lines, unmapped bits stay low
    ev_map_ok: assert property (@(posedge clk) disable iff (!arst_n)
        ((fc_events & ~EV_USED) == '0) && (fc_events[`EV_MTIME_BIT] == fc_events[`EV_TIMER_BIT]))
        else begin
            ev_errs++;
            $display("Fail fc_events_o: got %h, expected used bits %h with bits 7 and 16 equal",
                $sampled(fc_events), EV_USED);
        end

    // Event monitor
    always @(posedge clk) begin
        if (fc_events[`EV_MTIME_BIT]) mtime_cnt <= mtime_cnt + 1;
        if (fc_events[`EV_TIMER_BIT]) timer_cnt <= timer_cnt + 1;
        if (fc_events[`EV_REF_BIT])   ref_cnt   <= ref_cnt + 1;
        if (fc_events[`SW_EV_W-1:0] != '0) begin
            sw_cnt  <= sw_cnt + 1;
            sw_last <= fc_events[`SW_EV_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [`APB_ADDR_W-1:0] make_addr(input logic [3:0] slot,
                                                         input logic [2:0] idx);
        return {16'h0, slot, 7'h0, idx, 2'b00};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
            else begin
                val_errs++;
                $display("Fail %s: got %h, expected %h", name, got, exp);
            end
    endtask

    // Setup cycle, then access cycle, then idle
    task automatic apb_write(input logic [3:0] slot, input logic [2:0] idx,
                             input logic [31:0] data, input logic exp_err);
        @(posedge clk);
        apb_req.paddr   <= make_addr(slot, idx);
        apb_req.pwrite  <= 1'b1;
        apb_req.pwdata  <= data;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        err_exp         <= exp_err;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] slot, input logic [2:0] idx,
                            input logic [31:0] exp_data, input logic exp_err,
                            input logic chk_data);
        @(posedge clk);
        apb_req.paddr   <= make_addr(slot, idx);
        apb_req.pwrite  <= 1'b0;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        err_exp         <= exp_err;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        rd_chk          <= chk_data;
        rd_exp          <= exp_data;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        rd_chk          <= 1'b0;
    endtask

    task automatic wait_fc_bit(input int idx, input logic level, input int max_cyc);
        int n;
        n = 0;
        while (fc_events[idx] !== level && n < max_cyc) begin
            @(posedge clk);
            n++;
        end
        if (fc_events[idx] !== level) begin
            val_errs++;
            $display("Timed out after %0d cycles waiting for fc_events_o bit %0d", max_cyc, idx);
        end
    endtask

    // Each call gives n transitions of the slow clock
    task automatic toggle_slow(input int n);
        repeat (n) begin
            @(posedge clk);
            slow_clk <= ~slow_clk;
            repeat (EDGE_HOLD - 1) @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic test_readback();
        logic [31:0] v;
        repeat (2) begin
            rand_bits(32, v);
            apb_write(SLOT_GPIO, GPIO_DIR, v, 1'b0);
            dir_exp <= v;
            apb_read(SLOT_GPIO, GPIO_DIR, v, 1'b0, 1'b1);
            rand_bits(32, v);
            apb_write(SLOT_GPIO, GPIO_OUT, v, 1'b0);
            out_exp <= v;
            apb_read(SLOT_GPIO, GPIO_OUT, v, 1'b0, 1'b1);
            rand_bits(32, v);
            apb_write(SLOT_TIMER, TIMER_CMP, v, 1'b0);
            apb_read(SLOT_TIMER, TIMER_CMP, v, 1'b0, 1'b1);
            rand_bits(32, v);
            apb_write(SLOT_EVENT, EV_MASK, v, 1'b0);
            apb_read(SLOT_EVENT, EV_MASK, v, 1'b0, 1'b1);
        end
        apb_write(SLOT_EVENT, EV_MASK, `MASK_RST, 1'b0);
    endtask

    task automatic test_errors();
        logic [31:0] v;
        rand_bits(32, v);
        // Unmapped slot reads zero
        apb_read(4'd3, 3'd0, 32'h0, 1'b1, 1'b1);
        apb_write(4'd3, 3'd1, v, 1'b1);
        // Unknown offsets in each slot
        apb_read(SLOT_GPIO, 3'd6, 32'h0, 1'b1, 1'b0);
        apb_write(SLOT_TIMER, 3'd5, v, 1'b1);
        apb_read(SLOT_EVENT, 3'd3, 32'h0, 1'b1, 1'b0);
        // GPIO_IN is read-only
        apb_write(SLOT_GPIO, GPIO_IN, v, 1'b1);
        apb_read(SLOT_GPIO, GPIO_DIR, dir_exp, 1'b0, 1'b1);
    endtask

    task automatic test_gpio();
        logic [31:0] v;
        logic [31:0] k;
        logic [31:0] kb;
        rand_bits(32, v);
        rand_bits(5, k);
        kb = 32'h1 << k[4:0];
        @(posedge clk);
        gpio_in <= v;
        repeat (3) @(posedge clk);
        apb_read(SLOT_GPIO, GPIO_IN, v, 1'b0, 1'b1);
        // Pad k low and settled before its interrupt is enabled
        @(posedge clk);
        gpio_in <= v & ~kb;
        repeat (4) @(posedge clk);
        apb_write(SLOT_GPIO, GPIO_INT_EN, kb, 1'b0);
        @(posedge clk);
        gpio_in <= v | kb;
        wait_fc_bit(`EV_GPIO_BIT, 1'b1, 10);
        apb_read(SLOT_GPIO, GPIO_INT_STATUS, kb, 1'b0, 1'b1);
        // Write one to clear
        apb_write(SLOT_GPIO, GPIO_INT_STATUS, kb, 1'b0);
        repeat (3) @(posedge clk);
        expect_eq("fc_events_o[18]", {31'b0, fc_events[`EV_GPIO_BIT]}, 32'h0);
        apb_read(SLOT_GPIO, GPIO_INT_STATUS, 32'h0, 1'b0, 1'b1);
        apb_write(SLOT_GPIO, GPIO_INT_EN, 32'h0, 1'b0);
    endtask

    task automatic test_timer();
        logic [31:0] r;
        int          n;
        int          base_mt;
        int          base_tm;
        int          base_ref;
        rand_bits(2, r);
        n = 2 + int'(r[1:0]);
        apb_write(SLOT_TIMER, TIMER_CMP, n, 1'b0);
        apb_write(SLOT_TIMER, TIMER_COUNT, 32'h0, 1'b0);
        apb_write(SLOT_TIMER, TIMER_CTRL, 32'h1, 1'b0);
        base_mt  = mtime_cnt;
        base_tm  = timer_cnt;
        base_ref = ref_cnt;
        // N rising edges reach CMP once
        toggle_slow(2 * n);
        expect_eq("fc_events_o[7] pulses", mtime_cnt - base_mt, 32'd1);
        expect_eq("fc_events_o[16] pulses", timer_cnt - base_tm, 32'd1);
        expect_eq("fc_events_o[23] pulses", ref_cnt - base_ref, 2 * n);
        apb_read(SLOT_TIMER, TIMER_COUNT, 32'h0, 1'b0, 1'b1);
        toggle_slow(2);
        apb_read(SLOT_TIMER, TIMER_COUNT, 32'h1, 1'b0, 1'b1);
        // Frozen count
        @(posedge clk);
        stoptimer <= 1'b1;
        toggle_slow(4);
        apb_read(SLOT_TIMER, TIMER_COUNT, 32'h1, 1'b0, 1'b1);
        @(posedge clk);
        stoptimer <= 1'b0;
        expect_eq("fc_events_o[7] pulses", mtime_cnt - base_mt, 32'd1);
        apb_write(SLOT_TIMER, TIMER_CTRL, 32'h0, 1'b0);
    endtask

    task automatic test_events();
        logic [31:0] m;
        logic [31:0] p;
        int          base_sw;
        int          base_ref;
        rand_bits(32, m);
        m = (m | 32'h1) & ~(32'h1 << `EV_REF_BIT);
        apb_write(SLOT_EVENT, EV_MASK, m, 1'b0);
        apb_read(SLOT_EVENT, EV_MASK, m, 1'b0, 1'b1);
        rand_bits(`SW_EV_W, p);
        p       = p | 32'h1;
        base_sw = sw_cnt;
        apb_write(SLOT_EVENT, EV_SW, p, 1'b0);
        repeat (3) @(posedge clk);
        // One cycle wide, masked
        expect_eq("fc_events_o[6:0] pulses", sw_cnt - base_sw, 32'd1);
        expect_eq("fc_events_o[6:0]", {25'b0, sw_last}, p & m & 32'h7f);
        apb_read(SLOT_EVENT, EV_SW, 32'h0, 1'b0, 1'b1);
        base_ref = ref_cnt;
        toggle_slow(4);
        expect_eq("fc_events_o[23] pulses", ref_cnt - base_ref, 32'd0);
        apb_write(SLOT_EVENT, EV_MASK, `MASK_RST, 1'b0);
        toggle_slow(2);
        expect_eq("fc_events_o[23] pulses", ref_cnt - base_ref, 32'd2);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin
        int total;
        apb_req   = '0;
        gpio_in   = '0;
        slow_clk  = 1'b0;
        stoptimer = 1'b0;
        rd_chk    = 1'b0;
        rd_exp    = '0;
        err_exp   = 1'b0;
        dir_exp   = '0;
        out_exp   = '0;
        wait (arst_n === 1'b1);
        @(posedge clk);
        expect_eq("fc_events_o", fc_events, 32'h0);
        test_readback();
        test_errors();
        test_gpio();
        test_timer();
        test_events();
        repeat (4) @(posedge clk);
        total = rd_errs + bus_errs + pad_errs + ev_errs + val_errs;
        $display("Errors: prdata %0d, bus %0d, pads %0d, events %0d, values %0d",
            rd_errs, bus_errs, pad_errs, ev_errs, val_errs);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYC * 100);
        $display("Watchdog expired after %0d cycles, the run did not complete", LIMIT_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset generator
// 100 ns clock, reset held low for two cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 2;

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release reset on a rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule
